// File: ctrl_pkg.sv
package ctrl_pkg;

    // Instruction and field widths
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 20;

    // ADDI x0, x0, 0
    localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

    // RV32I major opcodes handled by the control unit
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Fetch sequencer states
    typedef enum logic [2:0] {
        FS_RUN,
        FS_LOAD_BUBBLE,
        FS_FLUSH1,
        FS_FLUSH2,
        FS_FLUSH3,
        FS_REDIRECT,
        FS_RESUME
    } fetch_state_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,   // register file value
        FWD_MEM  = 2'b01,   // result one stage ahead
        FWD_WB   = 2'b10    // result two stages ahead
    } fwd_sel_e;

    // Opcodes that read rs1
    function automatic logic reads_rs1(logic [6:0] opc);
        return opc inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
    endfunction

    // Opcodes that read rs2
    function automatic logic reads_rs2(logic [6:0] opc);
        return opc inside {OPC_BRANCH, OPC_STORE, OPC_OP};
    endfunction

    // Opcodes that write rd
    function automatic logic writes_rd(logic [6:0] opc);
        return opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP};
    endfunction

endpackage

// File: pipe_slots_if.sv
`timescale 1ns/10ps

interface pipe_slots_if #(
    parameter int PC_W = 32
);

    // Instruction words in flight, slot0 is the youngest
    logic [ctrl_pkg::INST_W-1:0] slot0;
    logic [ctrl_pkg::INST_W-1:0] slot1;
    logic [ctrl_pkg::INST_W-1:0] slot2;
    logic [ctrl_pkg::INST_W-1:0] slot3;
    logic [ctrl_pkg::INST_W-1:0] slot4;
    // PC of the execute slot
    logic [PC_W-1:0]             pc2;

    // History pipe side
    modport store (output slot0, slot1, slot2, slot3, slot4, pc2);

    // Fetch only looks at the newest word
    modport fetch (input slot0);

    // Decode and forwarding read everything
    modport decode (input slot0, slot1, slot2, slot3, slot4, pc2);

endinterface

// File: fetch_seq.sv
`timescale 1ns/10ps

module fetch_seq #(
    parameter int PC_W = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [ctrl_pkg::INST_W-1:0] inst,
    input  logic [PC_W-1:0]             target_pc,
    pipe_slots_if.fetch                 slots,
    output logic [ctrl_pkg::INST_W-1:0] next_inst,
    output logic [PC_W-1:0]             pc
);

    ctrl_pkg::fetch_state_e              state_q;
    ctrl_pkg::fetch_state_e              state_d;
    logic [PC_W-1:0]                     pc_d;
    logic [ctrl_pkg::REG_ADDR_W-1:0]     rd0;
    logic                                rs1_hit;
    logic                                rs2_hit;
    logic                                load_stall;
    logic                                ctrl_xfer;

    //////////////////////////////////////////////////
    // Hazard detection against slot0
    //////////////////////////////////////////////////

    // Destination of the word fetched last cycle
    assign rd0 = slots.slot0[11:7];

    // Incoming word reads what slot0 writes
    assign rs1_hit = ctrl_pkg::reads_rs1(inst[6:0]) && (inst[19:15] == rd0);
    assign rs2_hit = ctrl_pkg::reads_rs2(inst[6:0]) && (inst[24:20] == rd0);

    // Load data not ready in time so one bubble is needed
    assign load_stall = (slots.slot0[6:0] == ctrl_pkg::OPC_LOAD) && (rs1_hit || rs2_hit);

    // Jump or branch in slot0 with the target supplied from outside later
    assign ctrl_xfer = slots.slot0[6:0] inside
        {ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_JALR, ctrl_pkg::OPC_BRANCH};

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb
    begin
        case (state_q)
            ctrl_pkg::FS_RUN:
            begin
                // Load bubble has priority over the flush
                if (load_stall)
                    state_d = ctrl_pkg::FS_LOAD_BUBBLE;
                else if (ctrl_xfer)
                    state_d = ctrl_pkg::FS_FLUSH1;
                else
                    state_d = ctrl_pkg::FS_RUN;
            end
            ctrl_pkg::FS_LOAD_BUBBLE: state_d = ctrl_pkg::FS_RUN;
            ctrl_pkg::FS_FLUSH1:      state_d = ctrl_pkg::FS_FLUSH2;
            ctrl_pkg::FS_FLUSH2:      state_d = ctrl_pkg::FS_FLUSH3;
            ctrl_pkg::FS_FLUSH3:      state_d = ctrl_pkg::FS_REDIRECT;
            ctrl_pkg::FS_REDIRECT:    state_d = ctrl_pkg::FS_RESUME;
            ctrl_pkg::FS_RESUME:      state_d = ctrl_pkg::FS_RUN;
            default:                  state_d = ctrl_pkg::FS_RUN;
        endcase
    end

    // PC and pipe entry follow the state being entered
    always_comb
    begin
        case (state_d)
            ctrl_pkg::FS_LOAD_BUBBLE,
            ctrl_pkg::FS_FLUSH1,
            ctrl_pkg::FS_FLUSH2,
            ctrl_pkg::FS_FLUSH3:
            begin
                pc_d      = pc;
                next_inst = ctrl_pkg::NOP_INST;
            end
            ctrl_pkg::FS_REDIRECT:
            begin
                // Resolved target arrives here
                pc_d      = target_pc;
                next_inst = ctrl_pkg::NOP_INST;
            end
            default:
            begin
                pc_d      = pc + PC_W'(4);
                next_inst = inst;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ctrl_pkg::FS_RUN;
            pc      <= '0;
        end
        else
        begin
            state_q <= state_d;
            pc      <= pc_d;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Flushed slots really hold NOPs in the history pipe
    a_flush_nop: assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {ctrl_pkg::FS_FLUSH1, ctrl_pkg::FS_FLUSH2,
                        ctrl_pkg::FS_FLUSH3, ctrl_pkg::FS_REDIRECT}
        |-> slots.slot0 == ctrl_pkg::NOP_INST)
        else $error("non-NOP word in slot0 during flush");

    // Load bubble puts one NOP into the pipe and lasts one cycle
    a_bubble_one: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == ctrl_pkg::FS_LOAD_BUBBLE
        |-> (slots.slot0 == ctrl_pkg::NOP_INST) ##1 (state_q == ctrl_pkg::FS_RUN))
        else $error("load bubble not a single NOP followed by run");

endmodule

// File: inst_pipe.sv
`timescale 1ns/10ps

module inst_pipe #(
    parameter int PC_W = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [ctrl_pkg::INST_W-1:0] next_inst,
    input  logic [PC_W-1:0]             pc,
    pipe_slots_if.store                 slots
);

    // Instruction history, index 0 newest
    logic [ctrl_pkg::INST_W-1:0] inst_q [0:4];
    // PC history only as deep as execute needs
    logic [PC_W-1:0]             pc_q   [0:2];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 5; i++)
                inst_q[i] <= ctrl_pkg::NOP_INST;
            for (int i = 0; i < 3; i++)
                pc_q[i] <= '0;
        end
        else
        begin
            // Everything shifts every cycle, stalls arrive as NOPs
            inst_q[0] <= next_inst;
            for (int i = 1; i < 5; i++)
                inst_q[i] <= inst_q[i-1];
            pc_q[0] <= pc;
            for (int i = 1; i < 3; i++)
                pc_q[i] <= pc_q[i-1];
        end
    end

    assign slots.slot0 = inst_q[0];
    assign slots.slot1 = inst_q[1];
    assign slots.slot2 = inst_q[2];
    assign slots.slot3 = inst_q[3];
    assign slots.slot4 = inst_q[4];
    assign slots.pc2   = pc_q[2];

endmodule

// File: stage_decode.sv
`timescale 1ns/10ps

module stage_decode #(
    parameter int PC_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    pipe_slots_if.decode                    slots,
    output logic [ctrl_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [ctrl_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic                            rs1_rd_en,
    output logic                            rs2_rd_en,
    output ctrl_pkg::opcode_e               ex_opcode,
    output logic [2:0]                      ex_funct3,
    output logic [ctrl_pkg::IMM_W-1:0]      ex_imm,
    output logic [PC_W-1:0]                 ex_pc,
    output ctrl_pkg::opcode_e               mem_opcode,
    output logic [2:0]                      mem_funct3,
    output logic [ctrl_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic                            wb_en
);

    logic [ctrl_pkg::INST_W-1:0] ex_word;
    logic [ctrl_pkg::IMM_W-1:0]  imm_d;

    assign ex_word = slots.slot2;

    //////////////////////////////////////////////////
    // Execute immediate extraction
    //////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl_pkg::opcode_e'(ex_word[6:0]))
            // Upper immediates
            ctrl_pkg::OPC_LUI,
            ctrl_pkg::OPC_AUIPC:
                imm_d = ctrl_pkg::IMM_W'(ex_word[31:12]);
            // J-type bit shuffle, offset bit 0 implied
            ctrl_pkg::OPC_JAL:
                imm_d = ctrl_pkg::IMM_W'({ex_word[31], ex_word[19:12],
                                          ex_word[20], ex_word[30:21]});
            // I-type, zero-extended 12 bits
            ctrl_pkg::OPC_JALR,
            ctrl_pkg::OPC_LOAD,
            ctrl_pkg::OPC_OP_IMM:
                imm_d = ctrl_pkg::IMM_W'(ex_word[31:20]);
            // B-type
            ctrl_pkg::OPC_BRANCH:
                imm_d = ctrl_pkg::IMM_W'({ex_word[31], ex_word[7],
                                          ex_word[30:25], ex_word[11:8]});
            // S-type
            ctrl_pkg::OPC_STORE:
                imm_d = ctrl_pkg::IMM_W'({ex_word[31:25], ex_word[11:7]});
            // funct7 passed on for the ALU
            ctrl_pkg::OPC_OP:
                imm_d = ctrl_pkg::IMM_W'(ex_word[31:25]);
            default:
                imm_d = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////

    // Enables, cleared by reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rs1_rd_en <= 1'b0;
            rs2_rd_en <= 1'b0;
            wb_en     <= 1'b0;
        end
        else
        begin
            rs1_rd_en <= ctrl_pkg::reads_rs1(slots.slot1[6:0]);
            rs2_rd_en <= ctrl_pkg::reads_rs2(slots.slot1[6:0]);
            // Branch and store have no rd
            wb_en     <= ctrl_pkg::writes_rd(slots.slot4[6:0]);
        end
    end

    // Payload fields
    always_ff @(posedge clk)
    begin
        // Register read, slot1
        rs1_addr   <= slots.slot1[19:15];
        rs2_addr   <= slots.slot1[24:20];
        // Execute, slot2
        ex_opcode  <= ctrl_pkg::opcode_e'(ex_word[6:0]);
        ex_funct3  <= ex_word[14:12];
        ex_imm     <= imm_d;
        ex_pc      <= slots.pc2;
        // Memory, slot3
        mem_opcode <= ctrl_pkg::opcode_e'(slots.slot3[6:0]);
        mem_funct3 <= slots.slot3[14:12];
        // Write-back, slot4
        wb_addr    <= slots.slot4[11:7];
    end

    // Same instruction moves from memory to write-back one cycle later
    a_no_wb_on_store: assert property (@(posedge clk) disable iff (!rst_n)
        mem_opcode inside {ctrl_pkg::OPC_BRANCH, ctrl_pkg::OPC_STORE} |=> !wb_en)
        else $error("write-back enabled for branch or store");

endmodule

// File: forward_unit.sv
`timescale 1ns/10ps

module forward_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    pipe_slots_if.decode           slots,
    output ctrl_pkg::fwd_sel_e     fwd_rs1,
    output ctrl_pkg::fwd_sel_e     fwd_rs2
);

    logic [ctrl_pkg::REG_ADDR_W-1:0] rd_mem;
    logic [ctrl_pkg::REG_ADDR_W-1:0] rd_wb;

    // Destinations one and two stages ahead of execute
    assign rd_mem = slots.slot3[11:7];
    assign rd_wb  = slots.slot4[11:7];

    // Nearest producer wins, x0 never forwards
    function automatic ctrl_pkg::fwd_sel_e pick(
        logic [ctrl_pkg::REG_ADDR_W-1:0] src,
        logic [ctrl_pkg::REG_ADDR_W-1:0] rd_a,
        logic [ctrl_pkg::REG_ADDR_W-1:0] rd_b
    );
        if (src != '0 && src == rd_a)
            return ctrl_pkg::FWD_MEM;
        else if (src != '0 && src == rd_b)
            return ctrl_pkg::FWD_WB;
        else
            return ctrl_pkg::FWD_NONE;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fwd_rs1 <= ctrl_pkg::FWD_NONE;
            fwd_rs2 <= ctrl_pkg::FWD_NONE;
        end
        else
        begin
            fwd_rs1 <= pick(slots.slot2[19:15], rd_mem, rd_wb);
            fwd_rs2 <= pick(slots.slot2[24:20], rd_mem, rd_wb);
        end
    end

endmodule

// File: pipe_control.sv
`timescale 1ns/10ps

module pipe_control #(
    parameter int PC_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [ctrl_pkg::INST_W-1:0]     inst,
    input  logic [PC_W-1:0]                 target_pc,
    output logic [PC_W-1:0]                 pc,
    output logic [ctrl_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [ctrl_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic                            rs1_rd_en,
    output logic                            rs2_rd_en,
    output ctrl_pkg::opcode_e               ex_opcode,
    output logic [2:0]                      ex_funct3,
    output logic [ctrl_pkg::IMM_W-1:0]      ex_imm,
    output logic [PC_W-1:0]                 ex_pc,
    output ctrl_pkg::opcode_e               mem_opcode,
    output logic [2:0]                      mem_funct3,
    output logic [ctrl_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic                            wb_en,
    output ctrl_pkg::fwd_sel_e              fwd_rs1,
    output ctrl_pkg::fwd_sel_e              fwd_rs2
);

    // Word chosen by fetch for slot0
    logic [ctrl_pkg::INST_W-1:0] next_inst;

    pipe_slots_if #(.PC_W(PC_W)) slots ();

    //////////////////////////////////////////////////
    // Fetch and history
    //////////////////////////////////////////////////

    fetch_seq #(.PC_W(PC_W)) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .target_pc (target_pc),
        .slots     (slots.fetch),
        .next_inst (next_inst),
        .pc        (pc)
    );

    inst_pipe #(.PC_W(PC_W)) u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .next_inst (next_inst),
        .pc        (pc),
        .slots     (slots.store)
    );

    //////////////////////////////////////////////////
    // Per-stage controls
    //////////////////////////////////////////////////

    stage_decode #(.PC_W(PC_W)) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .slots      (slots.decode),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_rd_en  (rs1_rd_en),
        .rs2_rd_en  (rs2_rd_en),
        .ex_opcode  (ex_opcode),
        .ex_funct3  (ex_funct3),
        .ex_imm     (ex_imm),
        .ex_pc      (ex_pc),
        .mem_opcode (mem_opcode),
        .mem_funct3 (mem_funct3),
        .wb_addr    (wb_addr),
        .wb_en      (wb_en)
    );

    forward_unit u_fwd (
        .clk     (clk),
        .rst_n   (rst_n),
        .slots   (slots.decode),
        .fwd_rs1 (fwd_rs1),
        .fwd_rs2 (fwd_rs2)
    );

endmodule

// File: tb_pipe_control.sv
`timescale 1ns/10ps

module tb_pipe_control;

    localparam int PC_W = 32;
    localparam logic [31:0] NOP = ctrl_pkg::NOP_INST;
    localparam int RANDOM_CYCLES = 2000;
    // 16 reset cycles plus 2000 random and about 50 directed cycles leave ample margin
    localparam int MAX_CYCLES = 3000;

    logic clk;
    logic rst_n;
    logic [31:0] inst;
    logic [PC_W-1:0] target_pc;
    logic [PC_W-1:0] pc;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic rs1_rd_en;
    logic rs2_rd_en;
    ctrl_pkg::opcode_e ex_opcode;
    logic [2:0] ex_funct3;
    logic [19:0] ex_imm;
    logic [PC_W-1:0] ex_pc;
    ctrl_pkg::opcode_e mem_opcode;
    logic [2:0] mem_funct3;
    logic [4:0] wb_addr;
    logic wb_en;
    ctrl_pkg::fwd_sel_e fwd_rs1;
    ctrl_pkg::fwd_sel_e fwd_rs2;

    // Reference model state and expected outputs
    ctrl_pkg::fetch_state_e m_state;
    logic [PC_W-1:0] m_pc;
    logic [31:0] m_slot [0:4];
    logic [PC_W-1:0] m_pcq [0:2];
    logic [4:0] e_rs1_addr;
    logic [4:0] e_rs2_addr;
    logic [4:0] e_wb_addr;
    logic e_rs1_en;
    logic e_rs2_en;
    logic e_wb_en;
    logic [6:0] e_ex_op;
    logic [6:0] e_mem_op;
    logic [2:0] e_ex_f3;
    logic [2:0] e_mem_f3;
    logic [19:0] e_ex_imm;
    logic [PC_W-1:0] e_ex_pc;
    logic [1:0] e_fwd1;
    logic [1:0] e_fwd2;

    integer seed = 32'h8385f951;
    int cycle_count = 0;
    string cur_test;
    int test_errors;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [31:0] word;
    logic [PC_W-1:0] tgt;
    logic [PC_W-1:0] prev_pc;
    logic [31:0] xfer_word [0:2];
    logic [19:0] xfer_imm [0:2];
    logic [31:0] fwd_prog [0:8];

    pipe_control #(.PC_W(PC_W)) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .target_pc  (target_pc),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_rd_en  (rs1_rd_en),
        .rs2_rd_en  (rs2_rd_en),
        .ex_opcode  (ex_opcode),
        .ex_funct3  (ex_funct3),
        .ex_imm     (ex_imm),
        .ex_pc      (ex_pc),
        .mem_opcode (mem_opcode),
        .mem_funct3 (mem_funct3),
        .wb_addr    (wb_addr),
        .wb_en      (wb_en),
        .fwd_rs1    (fwd_rs1),
        .fwd_rs2    (fwd_rs2)
    );

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, simulation did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Opcode classes and field rules
    //////////////////////////////////////////////////

    function automatic logic src1_used(logic [6:0] op);
        return op inside {ctrl_pkg::OPC_JALR, ctrl_pkg::OPC_BRANCH, ctrl_pkg::OPC_LOAD,
                          ctrl_pkg::OPC_STORE, ctrl_pkg::OPC_OP_IMM, ctrl_pkg::OPC_OP};
    endfunction

    function automatic logic src2_used(logic [6:0] op);
        return op inside {ctrl_pkg::OPC_BRANCH, ctrl_pkg::OPC_STORE, ctrl_pkg::OPC_OP};
    endfunction

    // Every known opcode except branch and store
    function automatic logic has_dest(logic [6:0] op);
        return op inside {ctrl_pkg::OPC_LUI, ctrl_pkg::OPC_AUIPC, ctrl_pkg::OPC_JAL,
                          ctrl_pkg::OPC_JALR, ctrl_pkg::OPC_LOAD, ctrl_pkg::OPC_OP_IMM,
                          ctrl_pkg::OPC_OP};
    endfunction

    function automatic logic [19:0] imm_of(logic [31:0] w);
        case (w[6:0])
            ctrl_pkg::OPC_LUI, ctrl_pkg::OPC_AUIPC: return w[31:12];
            ctrl_pkg::OPC_JAL: return {w[31], w[19:12], w[20], w[30:21]};
            ctrl_pkg::OPC_JALR, ctrl_pkg::OPC_LOAD, ctrl_pkg::OPC_OP_IMM:
                return {8'd0, w[31:20]};
            ctrl_pkg::OPC_BRANCH: return {8'd0, w[31], w[7], w[30:25], w[11:8]};
            ctrl_pkg::OPC_STORE: return {8'd0, w[31:25], w[11:7]};
            ctrl_pkg::OPC_OP: return {13'd0, w[31:25]};
            default: return '0;
        endcase
    endfunction

    // Closest producer first and x0 excluded
    function automatic logic [1:0] expected_fwd(logic [4:0] src, logic [4:0] rd_m,
                                                logic [4:0] rd_w);
        if (src != 0 && src == rd_m)
            return ctrl_pkg::FWD_MEM;
        if (src != 0 && src == rd_w)
            return ctrl_pkg::FWD_WB;
        return ctrl_pkg::FWD_NONE;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    task automatic clear_model();
        m_state = ctrl_pkg::FS_RUN;
        m_pc = '0;
        for (int i = 0; i < 5; i++)
            m_slot[i] = NOP;
        for (int i = 0; i < 3; i++)
            m_pcq[i] = '0;
        // Payload registers keep clocking NOP fields during reset
        e_rs1_addr = NOP[19:15];
        e_rs2_addr = NOP[24:20];
        e_ex_op = NOP[6:0];
        e_ex_f3 = NOP[14:12];
        e_ex_imm = '0;
        e_ex_pc = '0;
        e_mem_op = NOP[6:0];
        e_mem_f3 = NOP[14:12];
        e_wb_addr = NOP[11:7];
        e_rs1_en = 1'b0;
        e_rs2_en = 1'b0;
        e_wb_en = 1'b0;
        e_fwd1 = ctrl_pkg::FWD_NONE;
        e_fwd2 = ctrl_pkg::FWD_NONE;
    endtask

    // One rising edge with inputs w and tpc
    task automatic advance_model(input logic [31:0] w, input logic [PC_W-1:0] tpc);
        ctrl_pkg::fetch_state_e nxt;
        logic [4:0] rd0;
        logic stall;
        logic xfer;
        logic [31:0] word_in;
        logic [PC_W-1:0] pc_n;
        rd0 = m_slot[0][11:7];
        stall = m_slot[0][6:0] == ctrl_pkg::OPC_LOAD &&
                ((src1_used(w[6:0]) && w[19:15] == rd0) ||
                 (src2_used(w[6:0]) && w[24:20] == rd0));
        xfer = m_slot[0][6:0] inside {ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_JALR,
                                      ctrl_pkg::OPC_BRANCH};
        case (m_state)
            ctrl_pkg::FS_RUN:
                nxt = stall ? ctrl_pkg::FS_LOAD_BUBBLE :
                      (xfer ? ctrl_pkg::FS_FLUSH1 : ctrl_pkg::FS_RUN);
            ctrl_pkg::FS_FLUSH1: nxt = ctrl_pkg::FS_FLUSH2;
            ctrl_pkg::FS_FLUSH2: nxt = ctrl_pkg::FS_FLUSH3;
            ctrl_pkg::FS_FLUSH3: nxt = ctrl_pkg::FS_REDIRECT;
            ctrl_pkg::FS_REDIRECT: nxt = ctrl_pkg::FS_RESUME;
            default: nxt = ctrl_pkg::FS_RUN;
        endcase
        // Bubbles hold pc and redirect loads the target
        if (nxt == ctrl_pkg::FS_REDIRECT)
        begin
            pc_n = tpc;
            word_in = NOP;
        end
        else if (nxt == ctrl_pkg::FS_RUN || nxt == ctrl_pkg::FS_RESUME)
        begin
            pc_n = m_pc + 4;
            word_in = w;
        end
        else
        begin
            pc_n = m_pc;
            word_in = NOP;
        end
        // Stage outputs from the slots before the shift
        e_rs1_addr = m_slot[1][19:15];
        e_rs2_addr = m_slot[1][24:20];
        e_rs1_en = src1_used(m_slot[1][6:0]);
        e_rs2_en = src2_used(m_slot[1][6:0]);
        e_ex_op = m_slot[2][6:0];
        e_ex_f3 = m_slot[2][14:12];
        e_ex_imm = imm_of(m_slot[2]);
        e_ex_pc = m_pcq[2];
        e_mem_op = m_slot[3][6:0];
        e_mem_f3 = m_slot[3][14:12];
        e_wb_addr = m_slot[4][11:7];
        e_wb_en = has_dest(m_slot[4][6:0]);
        e_fwd1 = expected_fwd(m_slot[2][19:15], m_slot[3][11:7], m_slot[4][11:7]);
        e_fwd2 = expected_fwd(m_slot[2][24:20], m_slot[3][11:7], m_slot[4][11:7]);
        for (int i = 4; i > 0; i--)
            m_slot[i] = m_slot[i-1];
        m_slot[0] = word_in;
        m_pcq[2] = m_pcq[1];
        m_pcq[1] = m_pcq[0];
        m_pcq[0] = m_pc;
        m_pc = pc_n;
        m_state = nxt;
    endtask

    //////////////////////////////////////////////////
    // Checking and stimulus helpers
    //////////////////////////////////////////////////

    task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("FAILED %s %s expected %h actual %h", cur_test, field, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_all();
        check("pc", m_pc, pc);
        check("rs1_addr", e_rs1_addr, rs1_addr);
        check("rs2_addr", e_rs2_addr, rs2_addr);
        check("rs1_rd_en", e_rs1_en, rs1_rd_en);
        check("rs2_rd_en", e_rs2_en, rs2_rd_en);
        check("ex_opcode", e_ex_op, ex_opcode);
        check("ex_funct3", e_ex_f3, ex_funct3);
        check("ex_imm", e_ex_imm, ex_imm);
        check("ex_pc", e_ex_pc, ex_pc);
        check("mem_opcode", e_mem_op, mem_opcode);
        check("mem_funct3", e_mem_f3, mem_funct3);
        check("wb_addr", e_wb_addr, wb_addr);
        check("wb_en", e_wb_en, wb_en);
        check("fwd_rs1", e_fwd1, fwd_rs1);
        check("fwd_rs2", e_fwd2, fwd_rs2);
    endtask

    // Drive, clock, then compare 1 ns after the edge
    task automatic step(input logic [31:0] w, input logic [PC_W-1:0] tpc);
        inst = w;
        target_pc = tpc;
        @(posedge clk);
        advance_model(w, tpc);
        #1;
        compare_all();
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("%s: PASS", cur_test);
        end
        else
        begin
            tests_failed++;
            $display("%s: FAIL with %0d mismatches", cur_test, test_errors);
        end
    endtask

    // Biased mix with registers limited to x0-x7 so hazards are frequent
    task automatic make_random_inst(output logic [31:0] w, output logic [PC_W-1:0] t);
        int pick;
        logic [6:0] op;
        pick = {$random(seed)} % 100;
        if (pick < 10)
        begin
            case ({$random(seed)} % 3)
                0: op = ctrl_pkg::OPC_JAL;
                1: op = ctrl_pkg::OPC_JALR;
                default: op = ctrl_pkg::OPC_BRANCH;
            endcase
        end
        else if (pick < 25)
            op = ctrl_pkg::OPC_LOAD;
        else
        begin
            case ({$random(seed)} % 5)
                0: op = ctrl_pkg::OPC_LUI;
                1: op = ctrl_pkg::OPC_AUIPC;
                2: op = ctrl_pkg::OPC_STORE;
                3: op = ctrl_pkg::OPC_OP_IMM;
                default: op = ctrl_pkg::OPC_OP;
            endcase
        end
        w = $random(seed);
        w[6:0] = op;
        w[11:10] = 2'b00;
        w[19:18] = 2'b00;
        w[24:23] = 2'b00;
        t = $random(seed);
        t[1:0] = 2'b00;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        inst = NOP;
        target_pc = '0;
        clear_model();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset_state");
        check("pc", 0, pc);
        check("rs1_rd_en", 0, rs1_rd_en);
        check("rs2_rd_en", 0, rs2_rd_en);
        check("wb_en", 0, wb_en);
        check("fwd_rs1", ctrl_pkg::FWD_NONE, fwd_rs1);
        check("fwd_rs2", ctrl_pkg::FWD_NONE, fwd_rs2);
        check("ex_imm", 0, ex_imm);
        compare_all();
        end_test();

        // slti x6, x2, 0x123 followed by NOPs
        begin_test("straight_line");
        for (int k = 0; k < 6; k++)
        begin
            prev_pc = m_pc;
            step(k == 0 ? 32'h1231_2313 : NOP, '0);
            check("pc_step", prev_pc + 4, pc);
            if (k == 2)
            begin
                check("rs1_addr", 2, rs1_addr);
                check("rs1_rd_en", 1, rs1_rd_en);
                check("rs2_rd_en", 0, rs2_rd_en);
            end
            if (k == 3)
            begin
                check("ex_opcode", ctrl_pkg::OPC_OP_IMM, ex_opcode);
                check("ex_funct3", 2, ex_funct3);
                check("ex_imm", 20'h00123, ex_imm);
            end
            if (k == 4)
                check("mem_funct3", 2, mem_funct3);
            if (k == 5)
            begin
                check("wb_addr", 6, wb_addr);
                check("wb_en", 1, wb_en);
            end
        end
        end_test();

        // lw x3, 0(x1) then add x4, x3, x2
        begin_test("load_use_bubble");
        step(32'h0000_A183, '0);
        prev_pc = m_pc;
        step(32'h0021_8233, '0);
        check("pc_hold", prev_pc, pc);
        step(32'h0021_8233, '0);
        check("pc_step", prev_pc + 4, pc);
        step(NOP, '0);
        check("ex_opcode", ctrl_pkg::OPC_LOAD, ex_opcode);
        step(NOP, '0);
        check("bubble_opcode", ctrl_pkg::OPC_OP_IMM, ex_opcode);
        check("bubble_imm", 0, ex_imm);
        step(NOP, '0);
        check("ex_opcode", ctrl_pkg::OPC_OP, ex_opcode);
        check("fwd_rs1", ctrl_pkg::FWD_WB, fwd_rs1);
        end_test();

        // jal x1, 8 / jalr x0, 0(x5) / beq x1, x2, 8
        begin_test("control_redirect");
        xfer_word[0] = 32'h0080_00EF;
        xfer_imm[0] = 20'd4;
        xfer_word[1] = 32'h0002_8067;
        xfer_imm[1] = 20'd0;
        xfer_word[2] = 32'h0020_8463;
        xfer_imm[2] = 20'd4;
        for (int i = 0; i < 3; i++)
        begin
            tgt = 32'h0000_1000 * (i + 1);
            for (int k = 0; k < 9; k++)
            begin
                prev_pc = m_pc;
                // Filler is addi x7, x0, 1
                step(k == 0 ? xfer_word[i] : 32'h0010_0393, tgt);
                if (k >= 1 && k <= 3)
                    check("pc_hold", prev_pc, pc);
                if (k == 4)
                    check("pc_redirect", tgt, pc);
                if (k == 5)
                    check("pc_resume", tgt + 4, pc);
                if (k == 3)
                begin
                    check("ex_opcode", xfer_word[i][6:0], ex_opcode);
                    check("ex_imm", xfer_imm[i], ex_imm);
                end
                if (k >= 4 && k <= 7)
                begin
                    check("nop_opcode", ctrl_pkg::OPC_OP_IMM, ex_opcode);
                    check("nop_imm", 0, ex_imm);
                end
                if (k == 8)
                    check("ex_imm", 1, ex_imm);
            end
        end
        end_test();

        // Producer of x5, back-to-back reader, one-apart reader of x6, x0 pair
        begin_test("forwarding");
        fwd_prog[0] = 32'h0010_0293;
        fwd_prog[1] = 32'h0052_8333;
        fwd_prog[2] = NOP;
        fwd_prog[3] = 32'h0003_03B3;
        fwd_prog[4] = 32'h0050_8013;
        fwd_prog[5] = 32'h0000_0433;
        for (int k = 6; k < 9; k++)
            fwd_prog[k] = NOP;
        for (int k = 0; k < 9; k++)
        begin
            step(fwd_prog[k], '0);
            if (k == 4)
            begin
                check("fwd_rs1", ctrl_pkg::FWD_MEM, fwd_rs1);
                check("fwd_rs2", ctrl_pkg::FWD_MEM, fwd_rs2);
            end
            if (k == 6)
            begin
                check("fwd_rs1", ctrl_pkg::FWD_WB, fwd_rs1);
                check("fwd_rs2", ctrl_pkg::FWD_NONE, fwd_rs2);
            end
            if (k == 8)
            begin
                check("fwd_rs1", ctrl_pkg::FWD_NONE, fwd_rs1);
                check("fwd_rs2", ctrl_pkg::FWD_NONE, fwd_rs2);
            end
        end
        end_test();

        begin_test("random_mix");
        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            make_random_inst(word, tgt);
            step(word, tgt);
        end
        end_test();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: pipe_control.f
ctrl_pkg.sv
pipe_slots_if.sv
fetch_seq.sv
inst_pipe.sv
stage_decode.sv
forward_unit.sv
pipe_control.sv
tb_pipe_control.sv
